// File: pattern_link.f
+incdir+source
source/video_timing_pkg.sv
source/training_pkg.sv
source/video_timing_gen.sv
source/training_pattern_gen.sv
source/lock_detector.sv
source/pattern_link_top.sv
test/pattern_link_assertions.sv
test/pattern_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the pattern link testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pattern_link_tb \
    -f pattern_link.f -o pattern_link_sim > build.log 2>&1 \
    && ./obj_dir/pattern_link_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: source/lock_detector.sv
// locks on a run of idle words, then checks the count; lane_err is sticky until reset
`timescale 1ns/1ns

`include "pattern_link_settings.svh"

module lock_detector
    import training_pkg::*;
(
    input  logic             clk,
    input  logic             rstn_cnt,
    input  pixel_beat_t      rx_beat,
    output logic             data_matched,
    output logic [LANES-1:0] lane_err
);

    localparam int RUN_W = $clog2(`LOCK_RUN + 1);  // run counter width
    localparam pattern_word_u IDLE_REF = IDLE_WORD;  // idle word viewed as lanes

    lock_state_e      state;      // detector FSM
    logic [RUN_W-1:0] run_cnt;    // idle words seen in this run
    pattern_word_u    exp_word;   // next expected count
    logic             cnt_seen;   // first count word arrived since lock
    logic [LANES-1:0] idle_diff;  // lanes off the idle word
    logic [LANES-1:0] lane_diff;  // lanes off the expected count
    logic             rx_idle;    // beat is a clean idle word

    // per-lane compare against both references
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign idle_diff[i] = (rx_beat.word.lanes[i] != IDLE_REF.lanes[i]);
        assign lane_diff[i] = (rx_beat.word.lanes[i] != exp_word.lanes[i]);
    end

    assign rx_idle = ~|idle_diff;

    always_ff @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            state        <= HUNT;
            run_cnt      <= '0;
            exp_word     <= '0;
            cnt_seen     <= 1'b0;
            data_matched <= 1'b0;
            lane_err     <= '0;
        end else if (rx_beat.valid) begin
            case (state)
                HUNT: begin
                    if (rx_idle) begin
                        state   <= RUN;
                        run_cnt <= RUN_W'(1);  // this word opens the run
                    end
                end
                RUN: begin
                    if (!rx_idle) begin
                        state   <= HUNT;  // run broken
                        run_cnt <= '0;
                    end else if (run_cnt == RUN_W'(`LOCK_RUN - 1)) begin
                        state        <= LOCKED;
                        run_cnt      <= '0;
                        data_matched <= 1'b1;
                        exp_word     <= '0;  // count starts at zero
                        cnt_seen     <= 1'b0;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                LOCKED: begin
                    // idle words still in the loopback are let through until
                    // the first count word comes back
                    if (cnt_seen || !rx_idle) begin
                        if (lane_diff == '0) begin
                            exp_word.raw <= exp_word.raw + 1'b1;
                            cnt_seen     <= 1'b1;
                        end else begin
                            lane_err     <= lane_err | lane_diff;  // sticky
                            data_matched <= 1'b0;
                            state        <= HUNT;
                            cnt_seen     <= 1'b0;
                        end
                    end
                end
                default: state <= HUNT;
            endcase
        end else begin
            exp_word <= '0;  // blanking restarts the next line at zero
        end
    end

endmodule

// File: source/pattern_link_settings.svh
// raster geometry and lock length for the training link; sizes must fit the 12-bit counters
`ifndef PATTERN_LINK_SETTINGS_SVH
`define PATTERN_LINK_SETTINGS_SVH

// horizontal timing, in pixel clocks
`define H_ACTIVE        16  // visible pixels per line
`define H_TOTAL         24  // full line period
`define H_FRONT_PORCH   2   // gap after active before hsync
`define H_SYNC          3   // hsync width

// vertical timing, in lines
`define V_ACTIVE        4   // visible lines per frame
`define V_TOTAL         8   // full frame period
`define V_FRONT_PORCH   1   // gap after active before vsync
`define V_SYNC          2   // vsync height

// lock detector
`define LOCK_RUN        6   // consecutive idle words before match

`endif

// File: source/pattern_link_top.sv
// link training source; rx_beat must be tx_beat looped back outside, a few clocks late
`timescale 1ns/1ns

module pattern_link_top
    import video_timing_pkg::*;
    import training_pkg::*;
(
    input  logic             clk,
    input  logic             rstn_cnt,
    input  pixel_beat_t      rx_beat,
    output video_sync_t      sync,
    output pixel_beat_t      tx_beat,
    output logic             data_matched,
    output logic [LANES-1:0] lane_err
);

    // raster source
    video_timing_gen u_timing (
        .clk      (clk),
        .rstn_cnt (rstn_cnt),
        .sync     (sync)
    );

    // pixel words on the raster
    training_pattern_gen u_pattern (
        .clk          (clk),
        .rstn_cnt     (rstn_cnt),
        .sync         (sync),
        .data_matched (data_matched),  // fed back from the detector
        .tx_beat      (tx_beat)
    );

    // checks the returned words
    lock_detector u_lock (
        .clk          (clk),
        .rstn_cnt     (rstn_cnt),
        .rx_beat      (rx_beat),
        .data_matched (data_matched),
        .lane_err     (lane_err)
    );

endmodule

// File: source/training_pattern_gen.sv
// idle word until match, then a per-line walking count; count wraps at 8 bits
`timescale 1ns/1ns

module training_pattern_gen
    import video_timing_pkg::*;
    import training_pkg::*;
(
    input  logic        clk,
    input  logic        rstn_cnt,
    input  video_sync_t sync,
    input  logic        data_matched,
    output pixel_beat_t tx_beat
);

    logic dm_q;        // data_matched one clock late
    logic dm_rise;     // match just declared
    logic line_start;  // first active pixel of a line

    assign dm_rise    = data_matched & ~dm_q;
    // tx_beat.valid is sync.lv one clock late, so it doubles as the lv history
    assign line_start = sync.lv & ~tx_beat.valid;

    // edge history
    always_ff @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            dm_q <= 1'b0;
        end else begin
            dm_q <= data_matched;
        end
    end

    // outgoing pixel, one clock behind the raster flags
    always_ff @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            tx_beat <= '0;
        end else begin
            tx_beat.valid <= sync.lv;
            if (!sync.lv) begin
                tx_beat.word.raw <= '0;  // blanking carries zero
            end else if (!data_matched) begin
                tx_beat.word.raw <= IDLE_WORD;  // training idle
            end else if (dm_rise || line_start) begin
                tx_beat.word.raw <= '0;  // count restart
            end else begin
                tx_beat.word.raw <= tx_beat.word.raw + 1'b1;  // walk
            end
        end
    end

endmodule

// File: source/training_pkg.sv
// training word types; the word is four 2-bit lanes, lane 3 in the top bits
package training_pkg;

    // lane geometry of the pixel word
    localparam int LANES   = 4;             // lanes per word
    localparam int LANE_W  = 2;             // bits per lane symbol
    localparam int WORD_W  = LANES * LANE_W;  // pixel word width

    // idle symbol sent on every active pixel before match
    localparam logic [WORD_W-1:0] IDLE_WORD = 8'b10_10_01_01;

    // one pixel word, read as a count or as lane symbols
    typedef union packed {
        logic [WORD_W-1:0]            raw;    // walking count value
        logic [LANES-1:0][LANE_W-1:0] lanes;  // lane 3 down to lane 0
    } pattern_word_u;

    // pixel on the link, valid marks active raster positions
    typedef struct packed {
        logic          valid;  // active pixel qualifier
        pattern_word_u word;   // payload
    } pixel_beat_t;

    // lock detector states
    typedef enum logic [1:0] {
        HUNT   = 2'd0,  // waiting for first idle word
        RUN    = 2'd1,  // counting a run of idle words
        LOCKED = 2'd2   // checking the walking count
    } lock_state_e;

endpackage

// File: source/video_timing_gen.sv
// free-running raster from the settings macros; no blanking control, frame never stalls
`timescale 1ns/1ns

`include "pattern_link_settings.svh"

module video_timing_gen
    import video_timing_pkg::*;
(
    input  logic        clk,
    input  logic        rstn_cnt,
    output video_sync_t sync
);

    // counter limits as count_t
    localparam count_t H_LAST    = count_t'(`H_TOTAL - 1);  // last pixel of a line
    localparam count_t V_LAST    = count_t'(`V_TOTAL - 1);  // last line of a frame
    localparam count_t H_ACT     = count_t'(`H_ACTIVE);
    localparam count_t V_ACT     = count_t'(`V_ACTIVE);
    localparam count_t HS_START  = count_t'(`H_ACTIVE + `H_FRONT_PORCH);  // hsync after this
    localparam count_t HS_END    = count_t'(`H_ACTIVE + `H_FRONT_PORCH + `H_SYNC);
    localparam count_t VS_START  = count_t'(`V_ACTIVE + `V_FRONT_PORCH);  // vsync from here
    localparam count_t VS_END    = count_t'(`V_ACTIVE + `V_FRONT_PORCH + `V_SYNC);
    localparam count_t FV_LAST   = count_t'(`V_ACTIVE + 1);  // fv spans one extra line

    count_t      pix_cnt;    // pixel within line
    count_t      line_cnt;   // line within frame
    logic        pix_wrap;   // last pixel of line
    logic        line_wrap;  // last line of frame
    video_sync_t sync_nxt;   // decoded flags before the register

    assign pix_wrap  = (pix_cnt == H_LAST);
    assign line_wrap = (line_cnt == V_LAST);

    // raster counters
    always_ff @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            pix_cnt  <= '0;
            line_cnt <= '0;
        end else begin
            pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;  // steps every clock
            if (pix_wrap) begin
                line_cnt <= line_wrap ? '0 : line_cnt + 1'b1;  // steps at end of line
            end
        end
    end

    // decode the four flags from the current count
    always_comb begin
        sync_nxt.lv    = (pix_cnt > '0) && (pix_cnt <= H_ACT)
                      && (line_cnt > '0) && (line_cnt <= V_ACT);  // 1-based active area
        sync_nxt.fv    = (line_cnt <= FV_LAST);  // line 0 is counted as lead-in
        sync_nxt.hsync = (pix_cnt > HS_START) && (pix_cnt <= HS_END);
        sync_nxt.vsync = (line_cnt >= VS_START) && (line_cnt < VS_END);
    end

    // registered sync, one cycle behind the counters
    always_ff @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            sync <= '0;
        end else begin
            sync <= sync_nxt;
        end
    end

endmodule

// File: source/video_timing_pkg.sv
// raster types only; geometry lives in the settings header, counts limited to 12 bits
package video_timing_pkg;

    // pixel and line counter width
    localparam int COUNT_W = 12;  // covers rasters up to 4095 per axis

    // unsigned pixel or line count
    typedef logic [COUNT_W-1:0] count_t;

    // raster qualifiers, all registered at the source
    typedef struct packed {
        logic fv;     // frame valid, lines 0..V_ACTIVE+1
        logic lv;     // line valid, active pixels only
        logic hsync;  // horizontal sync pulse
        logic vsync;  // vertical sync pulse
    } video_sync_t;

endpackage

// File: test/pattern_link_assertions.sv
// bound into pattern_link_top; idle count assumes rx_beat is the looped-back tx_beat
`timescale 1ns/1ns

`include "pattern_link_settings.svh"

module pattern_link_assertions
    import video_timing_pkg::*;
    import training_pkg::*;
(
    input logic             clk,
    input logic             rstn_cnt,
    input video_sync_t      sync,
    input pixel_beat_t      rx_beat,
    input logic             data_matched,
    input logic [LANES-1:0] lane_err
);

    int idle_run;  // clean idle beats in a row on rx

    always_ff @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            idle_run <= 0;
        end else if (rx_beat.valid) begin
            if (rx_beat.word.raw == IDLE_WORD) begin
                idle_run <= (idle_run < `LOCK_RUN) ? idle_run + 1 : idle_run;  // saturates
            end else begin
                idle_run <= 0;  // any other word breaks the run
            end
        end
    end

    // sync pulse sits in blanking only
    a_hsync_lv: assert property (@(posedge clk) disable iff (!rstn_cnt)
        !(sync.hsync && sync.lv))
        else $error("hsync high during line valid");

    a_lock_run: assert property (@(posedge clk) disable iff (!rstn_cnt)
        $rose(data_matched) |-> idle_run >= `LOCK_RUN)  // full idle run seen first
        else $error("data_matched rose after only %0d idle beats", idle_run);

    a_err_sticky: assert property (@(posedge clk) disable iff (!rstn_cnt)
        (lane_err & $past(lane_err)) == $past(lane_err))  // bits only ever set
        else $error("lane_err bit cleared without reset");

endmodule

bind pattern_link_top pattern_link_assertions u_checks (
    .clk          (clk),
    .rstn_cnt     (rstn_cnt),
    .sync         (sync),
    .rx_beat      (rx_beat),
    .data_matched (data_matched),
    .lane_err     (lane_err)
);

// File: test/pattern_link_tb.sv
// loopback is a fixed 3-stage delay with one lane fault per run; needs a simulator with timing
`timescale 1ns/1ns

`include "pattern_link_settings.svh"

module pattern_link_tb
    import video_timing_pkg::*;
    import training_pkg::*;
();

    localparam int          CLK_NS      = 40;
    localparam int          FRAME_CYC   = `H_TOTAL * `V_TOTAL;  // clocks per frame
    localparam int          WATCHDOG_NS = (6 * FRAME_CYC + 64) * CLK_NS;
    localparam logic [31:0] SEED        = 32'haa95c6d6;

    // expected state of the whole link stepped once per clock
    typedef struct packed {
        count_t           pix;   // pixel position
        count_t           line;  // line position
        video_sync_t      sync;
        pixel_beat_t      tx;
        logic             dm_q;  // match seen by the generator last clock
        lock_state_e      st;
        logic [3:0]       run;   // idle words in the current run
        pattern_word_u    exp;   // next count word expected back
        logic             seen;  // a count word has come back since lock
        logic             dm;
        logic [LANES-1:0] err;
    } model_t;

    logic             clk;
    logic             rstn_cnt;
    pixel_beat_t      rx_beat;
    video_sync_t      sync;
    pixel_beat_t      tx_beat;
    logic             data_matched;
    logic [LANES-1:0] lane_err;

    model_t      model;
    pixel_beat_t dly [0:1];   // first two loopback stages before rx_beat
    logic [31:0] lfsr_state;
    logic [1:0]  fault_lane;
    logic [1:0]  fault_val;   // xor pattern for the chosen lane
    logic        fault_req;
    logic        fault_done;
    logic        dm_prev;     // data_matched at the previous falling edge
    logic        fv_prev;
    int          cyc;
    int          last_fv_rise;
    int          checks;
    int          value_errs;
    int          other_errs;

    pattern_link_top dut0 (
        .clk          (clk),
        .rstn_cnt     (rstn_cnt),
        .rx_beat      (rx_beat),
        .sync         (sync),
        .tx_beat      (tx_beat),
        .data_matched (data_matched),
        .lane_err     (lane_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // next link state from the raster, generator and detector rules
    function automatic model_t model_step(input model_t m, input pixel_beat_t rx);
        model_t           n;
        int               p;
        int               l;
        logic             is_idle;
        logic [LANES-1:0] diff;
        n = m;
        p = int'(m.pix);
        l = int'(m.line);
        n.pix = count_t'((p + 1) % `H_TOTAL);
        if (p == `H_TOTAL - 1) begin
            n.line = count_t'((l + 1) % `V_TOTAL);
        end
        n.sync.lv    = (p >= 1) && (p <= `H_ACTIVE) && (l >= 1) && (l <= `V_ACTIVE);
        n.sync.fv    = (l <= `V_ACTIVE + 1);
        n.sync.hsync = (p >= `H_ACTIVE + `H_FRONT_PORCH + 1)
                    && (p <= `H_ACTIVE + `H_FRONT_PORCH + `H_SYNC);
        n.sync.vsync = (l >= `V_ACTIVE + `V_FRONT_PORCH)
                    && (l < `V_ACTIVE + `V_FRONT_PORCH + `V_SYNC);
        // generator runs one clock behind the flags
        n.dm_q     = m.dm;
        n.tx.valid = m.sync.lv;
        if (!m.sync.lv) begin
            n.tx.word.raw = '0;
        end else if (!m.dm) begin
            n.tx.word.raw = IDLE_WORD;
        end else if (!m.dm_q || !m.tx.valid) begin
            n.tx.word.raw = '0;  // new match or new line
        end else begin
            n.tx.word.raw = m.tx.word.raw + 8'd1;
        end
        // detector on the returned beat
        is_idle = (rx.word.raw == IDLE_WORD);
        for (int i = 0; i < LANES; i++) begin
            diff[i] = (rx.word.lanes[i] != m.exp.lanes[i]);
        end
        if (!rx.valid) begin
            n.exp.raw = '0;
        end else begin
            case (m.st)
                HUNT: begin
                    if (is_idle) begin
                        n.st  = RUN;
                        n.run = 4'd1;
                    end
                end
                RUN: begin
                    if (!is_idle) begin
                        n.st  = HUNT;
                        n.run = '0;
                    end else if (int'(m.run) + 1 == `LOCK_RUN) begin
                        n.st      = LOCKED;  // this word completes the run
                        n.run     = '0;
                        n.dm      = 1'b1;
                        n.exp.raw = '0;
                        n.seen    = 1'b0;
                    end else begin
                        n.run = m.run + 4'd1;
                    end
                end
                LOCKED: begin
                    if (m.seen || !is_idle) begin  // idle still in flight is passed
                        if (diff == '0) begin
                            n.exp.raw = m.exp.raw + 8'd1;
                            n.seen    = 1'b1;
                        end else begin
                            n.err  = m.err | diff;
                            n.dm   = 1'b0;
                            n.st   = HUNT;
                            n.seen = 1'b0;
                        end
                    end
                end
                default: n.st = HUNT;
            endcase
        end
        return n;
    endfunction

    task automatic flag_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        value_errs++;
        $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic wait_matched(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (data_matched !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (data_matched !== level) begin
            other_errs++;
            $display("timeout: %s within %0d cycles", what, max_cycles);
        end
    endtask

    // reference advances with the DUT
    always @(posedge clk or negedge rstn_cnt) begin
        if (!rstn_cnt) begin
            model = '0;
        end else begin
            model = model_step(model, rx_beat);
        end
    end

    // loopback and fault injection on the falling edge
    always @(negedge clk) begin
        pixel_beat_t b;
        b = dly[1];
        if (fault_req && !fault_done && b.valid && model.st == LOCKED && model.seen) begin
            b.word.lanes[fault_lane] = b.word.lanes[fault_lane] ^ fault_val;
            fault_done = 1'b1;
        end
        rx_beat <= b;
        dly[1]  <= dly[0];
        dly[0]  <= tx_beat;
    end

    // compare on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rstn_cnt) begin
            checks++;
            cyc++;
            if (sync !== model.sync) flag_value("sync", 32'(sync), 32'(model.sync));
            if (tx_beat !== model.tx) flag_value("tx_beat", 32'(tx_beat), 32'(model.tx));
            if (data_matched !== model.dm) begin
                flag_value("data_matched", 32'(data_matched), 32'(model.dm));
            end
            if (lane_err !== model.err) flag_value("lane_err", 32'(lane_err), 32'(model.err));
            // word made while unmatched must be idle
            if (!dm_prev && tx_beat.valid && tx_beat.word.raw != IDLE_WORD) begin
                flag_value("idle word", 32'(tx_beat.word.raw), 32'(IDLE_WORD));
            end
            if (!tx_beat.valid && tx_beat.word.raw != '0) begin
                flag_value("blank word", 32'(tx_beat.word.raw), 32'd0);
            end
            if (sync.fv && !fv_prev) begin
                if (last_fv_rise >= 0 && cyc - last_fv_rise != FRAME_CYC) begin
                    flag_value("frame period", 32'(cyc - last_fv_rise), 32'(FRAME_CYC));
                end
                last_fv_rise = cyc;
            end
            dm_prev = data_matched;
            fv_prev = sync.fv;
        end
    end

    initial begin
        logic [31:0]      bits;
        logic [LANES-1:0] want_err;
        rstn_cnt     = 1'b0;
        rx_beat      = '0;
        dly[0]       = '0;
        dly[1]       = '0;
        model        = '0;
        lfsr_state   = SEED;
        fault_req    = 1'b0;
        fault_done   = 1'b0;
        dm_prev      = 1'b0;
        fv_prev      = 1'b0;
        cyc          = 0;
        last_fv_rise = -1;
        checks       = 0;
        value_errs   = 0;
        other_errs   = 0;
        repeat (5) @(negedge clk);
        rstn_cnt <= 1'b1;
        wait_matched(1'b1, 2 * FRAME_CYC, "data_matched did not rise after reset");
        repeat (FRAME_CYC) @(negedge clk);  // one frame of walking counts
        if (!data_matched) begin
            other_errs++;
            $display("link lost its match while counting without any fault");
        end
        take_bits(2, bits);
        fault_lane = bits[1:0];
        take_bits(2, bits);
        fault_val = (bits[1:0] == 2'b00) ? 2'b01 : bits[1:0];  // never a no-op
        want_err  = LANES'(1) << fault_lane;
        @(posedge clk);
        fault_req = 1'b1;
        wait_matched(1'b0, 2 * FRAME_CYC, "data_matched did not drop after the lane fault");
        if (lane_err !== want_err) begin
            flag_value("lane_err after fault", 32'(lane_err), 32'(want_err));
        end
        wait_matched(1'b1, 2 * FRAME_CYC, "link did not lock again after the fault");
        repeat (FRAME_CYC) @(negedge clk);
        if (!data_matched) begin
            other_errs++;
            $display("link lost its match again after relock");
        end
        if (lane_err !== want_err) begin
            flag_value("lane_err after relock", 32'(lane_err), 32'(want_err));
        end
        $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs,
                 other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // generous bound on reset, lock, fault and relock
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: test sequence still running after %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule
